// ==== ahb_fir.f ====
logic/fir_pkg.sv
logic/fir_ifs.sv
logic/ahb_lite_slave.sv
logic/coefficient_loader.sv
logic/fir_datapath.sv
logic/ahb_fir_top.sv
bench/tb_clock_gen.sv
bench/tb_ahb_fir.sv

// ==== bench/tb_ahb_fir.sv ====
`timescale 1ns/1ps

module tb_ahb_fir;

    localparam int FRAC_BITS = 15;
    localparam int PERIOD_NS = 8;
    // cycles per bus transfer: address, data, turnaround
    localparam int XFER_CYC   = 3;
    localparam int SAMPLE_CYC = XFER_CYC * 7;
    localparam int LOAD_CYC   = XFER_CYC * 9;
    // tests 1-3, test 4, test 5, test 6
    localparam int TOTAL_CYC  = XFER_CYC * 41 + (LOAD_CYC + SAMPLE_CYC)
                              + (2 * LOAD_CYC + 4 * SAMPLE_CYC)
                              + (5 * LOAD_CYC + 20 * SAMPLE_CYC);

    logic           clk;
    logic           n_rst;
    logic           hsel;
    logic [3:0]     haddr;
    logic           hsize;
    logic [1:0]     htrans;
    logic           hwrite;
    fir_pkg::word_t hwdata;
    fir_pkg::word_t hrdata;
    logic           hresp;

    // expectations for the current data phase
    logic           chk_valid;
    logic           chk_resp;
    logic           chk_rd;
    fir_pkg::word_t chk_data;

    // model state
    fir_pkg::word_t pend_coef [fir_pkg::NUM_COEFF];
    fir_pkg::word_t act_coef  [fir_pkg::NUM_COEFF];
    fir_pkg::word_t hist      [fir_pkg::NUM_COEFF];
    fir_pkg::word_t last_out;
    logic           last_err;

    string  test_name;
    int     errors;
    int     errs_at_start;
    int     tests;
    integer seed;

    tb_clock_gen #(.PERIOD_NS(PERIOD_NS), .RESET_CYCLES(4)) clock_i (
        .clk   (clk),
        .n_rst (n_rst)
    );

    ahb_fir_top #(.FRAC_BITS(FRAC_BITS)) dut_i (
        .clk    (clk),
        .n_rst  (n_rst),
        .hsel   (hsel),
        .haddr  (haddr),
        .hsize  (hsize),
        .htrans (htrans),
        .hwrite (hwrite),
        .hwdata (hwdata),
        .hrdata (hrdata),
        .hresp  (hresp)
    );

    // hresp only where a data phase expects it
    resp_check: assert property (@(posedge clk) disable iff (!n_rst)
        hresp == (chk_valid && chk_resp))
    else begin
        errors = errors + 1;
        $display("FAIL %s: expected hresp %b, actual %b", test_name,
                 $sampled(chk_valid && chk_resp), $sampled(hresp));
    end

    rdata_check: assert property (@(posedge clk) disable iff (!n_rst)
        (chk_valid && chk_rd) |-> hrdata == chk_data)
    else begin
        errors = errors + 1;
        $display("FAIL %s: expected hrdata %h, actual %h", test_name,
                 $sampled(chk_data), $sampled(hrdata));
    end

    // one transfer, address phase then data phase
    task automatic xfer(input logic wr, input logic [3:0] addr, input logic size,
                        input fir_pkg::word_t wdata, input logic exp_resp,
                        input logic check_rd, input fir_pkg::word_t exp_rd,
                        output fir_pkg::word_t rd);
        @(posedge clk);
        hsel   <= 1'b1;
        htrans <= 2'b10;
        haddr  <= addr;
        hsize  <= size;
        hwrite <= wr;
        @(posedge clk);
        hsel      <= 1'b0;
        htrans    <= 2'b00;
        hwdata    <= wdata;
        chk_valid <= 1'b1;
        chk_resp  <= exp_resp;
        chk_rd    <= check_rd;
        chk_data  <= exp_rd;
        // mid data phase, hrdata settled
        @(negedge clk);
        rd = hrdata;
        @(posedge clk);
        chk_valid <= 1'b0;
    endtask

    task automatic wr(input logic [3:0] addr, input logic size,
                      input fir_pkg::word_t data, input logic exp_resp);
        fir_pkg::word_t unused;
        xfer(1'b1, addr, size, data, exp_resp, 1'b0, '0, unused);
    endtask

    task automatic rd_chk(input logic [3:0] addr, input logic size,
                          input fir_pkg::word_t exp, input logic exp_resp);
        fir_pkg::word_t unused;
        xfer(1'b0, addr, size, '0, exp_resp, !exp_resp, exp, unused);
    endtask

    task automatic rd_val(input logic [3:0] addr, input logic size,
                          output fir_pkg::word_t v);
        xfer(1'b0, addr, size, '0, 1'b0, 1'b0, '0, v);
    endtask

    // poll busy in status until clear
    task automatic wait_idle();
        fir_pkg::word_t st;
        st = 16'h0001;
        while (st[0]) begin
            rd_val(fir_pkg::ADDR_STATUS, 1'b1, st);
        end
    endtask

    // write pending taps, set load flag, poll until the loader drops it
    task automatic load_coeffs();
        fir_pkg::word_t flag;
        for (int k = 0; k < fir_pkg::NUM_COEFF; k++) begin
            wr(fir_pkg::ADDR_COEFF0 + 4'(2 * k), 1'b1, pend_coef[k], 1'b0);
        end
        wr(fir_pkg::ADDR_NEW_COEFF, 1'b0, 16'h0001, 1'b0);
        flag = 16'h0001;
        while (flag != 0) begin
            rd_val(fir_pkg::ADDR_NEW_COEFF, 1'b0, flag);
        end
        act_coef = pend_coef;
    endtask

    // write one sample, predict, poll, check status and result
    task automatic run_sample(input fir_pkg::word_t s);
        logic [35:0] acc;
        acc = '0;
        wr(fir_pkg::ADDR_SAMPLE, 1'b1, s, 1'b0);
        for (int k = fir_pkg::NUM_COEFF - 1; k > 0; k--) begin
            hist[k] = hist[k-1];
        end
        hist[0] = s;
        // sum of tap k times sample k writes ago
        for (int k = 0; k < fir_pkg::NUM_COEFF; k++) begin
            acc = acc + 36'(act_coef[k]) * 36'(hist[k]);
        end
        acc = acc >> FRAC_BITS;
        last_out = acc[15:0];
        last_err = |acc[35:16];
        wait_idle();
        rd_chk(fir_pkg::ADDR_STATUS, 1'b1, {7'b0, last_err, 8'h00}, 1'b0);
        rd_chk(fir_pkg::ADDR_RESULT, 1'b1, last_out, 1'b0);
    endtask

    task automatic start_test(input string name);
        test_name = name;
        errs_at_start = errors;
    endtask

    // let the last data-phase check fire before the name moves on
    task automatic end_test();
        @(negedge clk);
        tests = tests + 1;
        if (errors == errs_at_start) begin
            $display("PASS %s", test_name);
        end else begin
            $display("%s: %0d errors", test_name, errors - errs_at_start);
        end
    endtask

    initial begin
        #(TOTAL_CYC * 3 / 2 * PERIOD_NS);
        $display("timeout: tests did not complete in %0d cycles", TOTAL_CYC * 3 / 2);
        $display("Finished with errors");
        $finish;
    end

    initial begin
        fir_pkg::word_t v;
        fir_pkg::word_t junk;
        logic [7:0]     b0;
        logic [7:0]     b1;
        logic [3:0]     a;

        hsel      <= 1'b0;
        haddr     <= '0;
        hsize     <= 1'b0;
        htrans    <= 2'b00;
        hwrite    <= 1'b0;
        hwdata    <= '0;
        chk_valid <= 1'b0;
        chk_resp  <= 1'b0;
        chk_rd    <= 1'b0;
        chk_data  <= '0;
        errors    = 0;
        tests     = 0;
        seed      = 32'haca5;
        last_out  = '0;
        last_err  = 1'b0;
        pend_coef = '{default: '0};
        act_coef  = '{default: '0};
        hist      = '{default: '0};
        wait (n_rst === 1'b1);

        start_test("reset_values");
        rd_chk(fir_pkg::ADDR_STATUS, 1'b1, 16'h0000, 1'b0);
        rd_chk(fir_pkg::ADDR_RESULT, 1'b1, 16'h0000, 1'b0);
        rd_chk(fir_pkg::ADDR_NEW_COEFF, 1'b0, 16'h0000, 1'b0);
        end_test();

        start_test("coeff_lanes");
        for (int k = 0; k < fir_pkg::NUM_COEFF; k++) begin
            a = fir_pkg::ADDR_COEFF0 + 4'(2 * k);
            v = 16'ha5c3 + 16'(k) * 16'h0101;
            wr(a, 1'b1, v, 1'b0);
            rd_chk(a, 1'b1, v, 1'b0);
            // even byte low lane, odd byte high lane
            rd_chk(a, 1'b0, {8'h00, v[7:0]}, 1'b0);
            rd_chk(a + 4'd1, 1'b0, {v[15:8], 8'h00}, 1'b0);
            b0 = ~v[7:0];
            b1 = v[7:0] ^ 8'h3c;
            // junk on the unused lane must be ignored
            wr(a, 1'b0, {8'hee, b0}, 1'b0);
            wr(a + 4'd1, 1'b0, {b1, 8'hdd}, 1'b0);
            rd_chk(a, 1'b1, {b1, b0}, 1'b0);
            pend_coef[k] = {b1, b0};
        end
        end_test();

        start_test("error_response");
        wr(fir_pkg::ADDR_STATUS, 1'b1, 16'hffff, 1'b1);
        wr(fir_pkg::ADDR_RESULT, 1'b1, 16'hffff, 1'b1);
        wr(4'd1, 1'b0, 16'hff00, 1'b1);
        wr(4'd3, 1'b0, 16'hff00, 1'b1);
        rd_chk(fir_pkg::ADDR_STATUS, 1'b1, {7'b0, last_err, 8'h00}, 1'b0);
        rd_chk(fir_pkg::ADDR_RESULT, 1'b1, last_out, 1'b0);
        wr(fir_pkg::ADDR_RESERVED, 1'b0, 16'hff00, 1'b1);
        xfer(1'b0, fir_pkg::ADDR_RESERVED, 1'b0, '0, 1'b1, 1'b0, '0, junk);
        xfer(1'b0, fir_pkg::ADDR_RESERVED, 1'b1, '0, 1'b1, 1'b0, '0, junk);
        // halfword at 14 shows the reserved byte on the upper lane
        rd_chk(fir_pkg::ADDR_NEW_COEFF, 1'b1, 16'h0000, 1'b0);
        end_test();

        start_test("coeff_load");
        pend_coef = '{16'h8000, 16'h4000, 16'h2000, 16'h1000};
        load_coeffs();
        run_sample(16'h00ab);
        end_test();

        // history still partly empty, then saturating taps
        start_test("filter_results");
        pend_coef = '{16'h4000, 16'h2000, 16'h1000, 16'h0800};
        load_coeffs();
        run_sample(16'h1234);
        run_sample(16'h8000);
        pend_coef = '{default: 16'hffff};
        load_coeffs();
        run_sample(16'hffff);
        run_sample(16'hffff);
        end_test();

        start_test("random_samples");
        for (int i = 0; i < 20; i++) begin
            // fresh taps every fourth sample
            if (i % 4 == 0) begin
                for (int k = 0; k < fir_pkg::NUM_COEFF; k++) begin
                    pend_coef[k] = 16'($random(seed));
                end
                load_coeffs();
            end
            run_sample(16'($random(seed)));
        end
        end_test();

        $display("tests run %0d, errors %0d", tests, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// ==== bench/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 8,
    parameter int RESET_CYCLES = 4
) (
    output logic clk,
    output logic n_rst
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2.0);
            clk = ~clk;
        end
    end

    // reset low for the first few edges, released on an edge
    initial begin
        n_rst = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        n_rst <= 1'b1;
    end

endmodule

// ==== logic/ahb_fir_top.sv ====
`timescale 1ns/1ps

module ahb_fir_top #(
    parameter int FRAC_BITS = 15
) (
    input  logic           clk,
    input  logic           n_rst,
    input  logic           hsel,
    input  logic [3:0]     haddr,
    input  logic           hsize,
    input  logic [1:0]     htrans,
    input  logic           hwrite,
    input  fir_pkg::word_t hwdata,
    output fir_pkg::word_t hrdata,
    output logic           hresp
);

    // register map to loader and filter
    coeff_if  coeff_bus ();
    // samples in, results back to the map
    sample_if samp_bus ();

    ahb_lite_slave slave_i (
        .clk    (clk),
        .n_rst  (n_rst),
        .hsel   (hsel),
        .haddr  (haddr),
        .hsize  (hsize),
        .htrans (htrans),
        .hwrite (hwrite),
        .hwdata (hwdata),
        .hrdata (hrdata),
        .hresp  (hresp),
        .coeff  (coeff_bus.slave),
        .samp   (samp_bus.slave)
    );

    coefficient_loader loader_i (
        .clk   (clk),
        .n_rst (n_rst),
        .coeff (coeff_bus.loader),
        .samp  (samp_bus.monitor)
    );

    fir_datapath #(
        .FRAC_BITS (FRAC_BITS)
    ) datapath_i (
        .clk   (clk),
        .n_rst (n_rst),
        .coeff (coeff_bus.filter),
        .samp  (samp_bus.filter)
    );

endmodule

// ==== logic/fir_datapath.sv ====
`timescale 1ns/1ps

module fir_datapath #(
    parameter int FRAC_BITS = 15
) (
    input  logic     clk,
    input  logic     n_rst,
    coeff_if.filter  coeff,
    sample_if.filter samp
);

    localparam int ACC_W = 36;

    fir_pkg::datapath_state_t state_q;
    fir_pkg::word_t           tap_q  [fir_pkg::NUM_COEFF];
    // slot 0 newest, slot k is k samples back
    fir_pkg::word_t           hist_q [fir_pkg::NUM_COEFF];
    fir_pkg::coeff_idx_t      k_q;
    logic [ACC_W-1:0]         acc_q;
    logic [31:0]              product;
    logic [ACC_W-1:0]         sum;
    logic [ACC_W-1:0]         scaled;
    logic                     modwait_q;
    logic                     err_q;
    fir_pkg::word_t           fir_out_q;

    // one tap per cycle
    assign product = tap_q[k_q] * hist_q[k_q];
    assign sum     = acc_q + ACC_W'(product);
    // drop the coefficient fraction
    assign scaled  = sum >> FRAC_BITS;

    // tap registers, written by the loader
    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            tap_q <= '{default: '0};
        end else if (coeff.load_coeff) begin
            tap_q[coeff.coefficient_num] <= coeff.fir_coefficient;
        end
    end

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            state_q   <= fir_pkg::DP_IDLE;
            hist_q    <= '{default: '0};
            k_q       <= '0;
            acc_q     <= '0;
            modwait_q <= 1'b0;
            err_q     <= 1'b0;
            fir_out_q <= '0;
        end else begin
            case (state_q)
                fir_pkg::DP_IDLE: begin
                    // held off while a coefficient load is pending
                    if (samp.data_ready && !coeff.new_coefficient_set) begin
                        state_q   <= fir_pkg::DP_SHIFT;
                        modwait_q <= 1'b1;
                    end
                end
                fir_pkg::DP_SHIFT: begin
                    // newest sample in, oldest falls off
                    hist_q[0] <= samp.sample_data;
                    for (int i = 1; i < fir_pkg::NUM_COEFF; i++) begin
                        hist_q[i] <= hist_q[i-1];
                    end
                    acc_q   <= '0;
                    k_q     <= '0;
                    state_q <= fir_pkg::DP_MAC;
                end
                fir_pkg::DP_MAC: begin
                    acc_q <= sum;
                    k_q   <= k_q + 2'd1;
                    if (k_q == fir_pkg::coeff_idx_t'(fir_pkg::NUM_COEFF - 1)) begin
                        // last tap, publish result
                        fir_out_q <= scaled[15:0];
                        err_q     <= |scaled[ACC_W-1:16];
                        modwait_q <= 1'b0;
                        state_q   <= fir_pkg::DP_DONE;
                    end
                end
                fir_pkg::DP_DONE: begin
                    state_q <= fir_pkg::DP_IDLE;
                end
                default: begin
                    state_q <= fir_pkg::DP_IDLE;
                end
            endcase
        end
    end

    assign samp.modwait = modwait_q;
    assign samp.fir_out = fir_out_q;
    assign samp.err     = err_q;

    // shift plus four MAC cycles per sample
    busy_five_cycles: assert property (@(posedge clk) disable iff (!n_rst)
        $rose(samp.modwait) |-> samp.modwait [*5] ##1 !samp.modwait);

endmodule

// ==== logic/coefficient_loader.sv ====
`timescale 1ns/1ps

module coefficient_loader (
    input  logic      clk,
    input  logic      n_rst,
    coeff_if.loader   coeff,
    sample_if.monitor samp
);

    fir_pkg::loader_state_t state_q;
    // tap being copied
    fir_pkg::coeff_idx_t    idx_q;

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            state_q <= fir_pkg::LD_IDLE;
            idx_q   <= '0;
        end else begin
            case (state_q)
                fir_pkg::LD_IDLE: begin
                    // wait for a request while the filter is idle
                    if (coeff.new_coefficient_set && !samp.modwait) begin
                        state_q <= fir_pkg::LD_LOAD;
                        idx_q   <= '0;
                    end
                end
                fir_pkg::LD_LOAD: begin
                    // wraps back to zero after the last tap
                    idx_q <= idx_q + 2'd1;
                    if (idx_q == fir_pkg::coeff_idx_t'(fir_pkg::NUM_COEFF - 1)) begin
                        state_q <= fir_pkg::LD_CLEAR;
                    end
                end
                fir_pkg::LD_CLEAR: begin
                    state_q <= fir_pkg::LD_IDLE;
                end
                default: begin
                    state_q <= fir_pkg::LD_IDLE;
                end
            endcase
        end
    end

    assign coeff.coefficient_num = idx_q;
    assign coeff.load_coeff      = (state_q == fir_pkg::LD_LOAD);
    // one pulse, slave drops the flag next edge
    assign coeff.clear_new_coeff = (state_q == fir_pkg::LD_CLEAR);

    // load only from an idle request, four taps then the clear pulse
    load_burst: assert property (@(posedge clk) disable iff (!n_rst)
        $rose(coeff.load_coeff) |-> $past(coeff.new_coefficient_set && !samp.modwait)
            ##0 coeff.load_coeff [*4] ##1 (coeff.clear_new_coeff && !coeff.load_coeff));

endmodule

// ==== logic/ahb_lite_slave.sv ====
`timescale 1ns/1ps

module ahb_lite_slave (
    input  logic           clk,
    input  logic           n_rst,
    input  logic           hsel,
    input  logic [3:0]     haddr,
    input  logic           hsize,
    input  logic [1:0]     htrans,
    input  logic           hwrite,
    input  fir_pkg::word_t hwdata,
    output fir_pkg::word_t hrdata,
    output logic           hresp,
    coeff_if.slave         coeff,
    sample_if.slave        samp
);

    // byte-wide register table, index is the byte address
    logic [15:0][7:0] regs_q;
    logic [15:0][7:0] regs_d;

    // registered address phase
    logic       dp_valid_q;
    logic [3:0] dp_addr_q;
    logic       dp_size_q;
    logic       dp_write_q;

    logic       data_ready_q;
    logic       data_ready_d;
    // previous modwait, for the rising edge
    logic       modwait_q;

    // even and odd byte of the addressed halfword
    logic [3:0] lo_addr;
    logic [3:0] hi_addr;
    logic       bad_access;
    logic [3:0] coeff_addr;

    assign lo_addr = {dp_addr_q[3:1], 1'b0};
    assign hi_addr = {dp_addr_q[3:1], 1'b1};

    // writes into status/result, anything at the reserved byte
    assign bad_access = dp_valid_q &&
                        ((dp_write_q && (dp_addr_q < fir_pkg::ADDR_SAMPLE)) ||
                         (dp_addr_q == fir_pkg::ADDR_RESERVED));

    // single-cycle error response in the data phase
    assign hresp = bad_access;

    // tap k lives at F0 + 2k
    assign coeff_addr = fir_pkg::ADDR_COEFF0 + {1'b0, coeff.coefficient_num, 1'b0};
    assign coeff.fir_coefficient = {regs_q[coeff_addr + 4'd1], regs_q[coeff_addr]};
    assign coeff.new_coefficient_set = |regs_q[fir_pkg::ADDR_NEW_COEFF];

    assign samp.sample_data = {regs_q[fir_pkg::ADDR_SAMPLE + 4'd1], regs_q[fir_pkg::ADDR_SAMPLE]};
    assign samp.data_ready = data_ready_q;

    always_comb begin
        regs_d = regs_q;
        data_ready_d = data_ready_q;
        hrdata = '0;

        // status byte 0 busy, byte 1 err
        regs_d[fir_pkg::ADDR_STATUS] = {7'b0, data_ready_q | samp.modwait};
        regs_d[fir_pkg::ADDR_STATUS + 4'd1] = {7'b0, samp.err};
        regs_d[fir_pkg::ADDR_RESULT] = samp.fir_out[7:0];
        regs_d[fir_pkg::ADDR_RESULT + 4'd1] = samp.fir_out[15:8];

        // loader done, drop the load flag
        if (coeff.clear_new_coeff) begin
            regs_d[fir_pkg::ADDR_NEW_COEFF] = '0;
        end

        // filter has taken the sample
        if (samp.modwait && !modwait_q) begin
            data_ready_d = 1'b0;
        end

        if (dp_valid_q && !bad_access) begin
            if (dp_write_q) begin
                if (dp_size_q) begin
                    regs_d[lo_addr] = hwdata[7:0];
                    // reserved byte stays zero
                    if (hi_addr != fir_pkg::ADDR_RESERVED) begin
                        regs_d[hi_addr] = hwdata[15:8];
                    end
                    // a new halfword sample overrides the clear
                    if (lo_addr == fir_pkg::ADDR_SAMPLE) begin
                        data_ready_d = 1'b1;
                    end
                end else if (dp_addr_q[0]) begin
                    regs_d[dp_addr_q] = hwdata[15:8];
                end else begin
                    regs_d[dp_addr_q] = hwdata[7:0];
                end
            end else begin
                if (dp_size_q) begin
                    hrdata = {regs_q[hi_addr], regs_q[lo_addr]};
                end else if (dp_addr_q[0]) begin
                    // odd byte on the upper lane
                    hrdata[15:8] = regs_q[dp_addr_q];
                end else begin
                    hrdata[7:0] = regs_q[dp_addr_q];
                end
            end
        end
    end

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            regs_q       <= '0;
            dp_valid_q   <= 1'b0;
            dp_addr_q    <= '0;
            dp_size_q    <= 1'b0;
            dp_write_q   <= 1'b0;
            data_ready_q <= 1'b0;
            modwait_q    <= 1'b0;
        end else begin
            regs_q       <= regs_d;
            // address phase, used one cycle later
            dp_valid_q   <= hsel && (htrans != 2'b00);
            dp_addr_q    <= haddr;
            dp_size_q    <= hsize;
            dp_write_q   <= hwrite;
            data_ready_q <= data_ready_d;
            modwait_q    <= samp.modwait;
        end
    end

    // rejected transfer leaves the writable bytes alone
    error_changes_nothing: assert property (@(posedge clk) disable iff (!n_rst)
        (hresp && !coeff.clear_new_coeff) |=> $stable(regs_q[15:4]));

    // sample handshake only ends once the filter is busy
    ready_falls_after_modwait: assert property (@(posedge clk) disable iff (!n_rst)
        $fell(data_ready_q) |-> $past(samp.modwait));

endmodule

// ==== logic/fir_ifs.sv ====
`timescale 1ns/1ps

// coefficient path from the register map into the filter taps
interface coeff_if;
    logic                new_coefficient_set;
    fir_pkg::word_t      fir_coefficient;
    fir_pkg::coeff_idx_t coefficient_num;
    logic                load_coeff;
    logic                clear_new_coeff;

    modport slave (
        output fir_coefficient, new_coefficient_set,
        input  coefficient_num, clear_new_coeff
    );

    modport loader (
        input  fir_coefficient, new_coefficient_set,
        output coefficient_num, clear_new_coeff, load_coeff
    );

    // pending load request keeps the filter from starting
    modport filter (
        input coefficient_num, fir_coefficient, load_coeff, new_coefficient_set
    );
endinterface

// sample in, filtered result and status out
interface sample_if;
    fir_pkg::word_t sample_data;
    logic           data_ready;
    logic           modwait;
    fir_pkg::word_t fir_out;
    logic           err;

    // status and result bytes are refreshed from the filter side
    modport slave (
        output sample_data, data_ready,
        input  modwait, fir_out, err
    );

    modport filter (
        output modwait, fir_out, err,
        input  sample_data, data_ready
    );

    // loader only needs to know the filter is idle
    modport monitor (
        input modwait
    );
endinterface

// ==== logic/fir_pkg.sv ====
package fir_pkg;

    // bus word, also the sample and coefficient width
    typedef logic [15:0] word_t;

    // selects one of the four taps
    typedef logic [1:0] coeff_idx_t;

    localparam int NUM_COEFF = 4;

    // byte offsets in the 16-byte register map
    localparam logic [3:0] ADDR_STATUS    = 4'd0;
    localparam logic [3:0] ADDR_RESULT    = 4'd2;
    localparam logic [3:0] ADDR_SAMPLE    = 4'd4;
    // F1..F3 follow every two bytes
    localparam logic [3:0] ADDR_COEFF0    = 4'd6;
    localparam logic [3:0] ADDR_NEW_COEFF = 4'd14;
    localparam logic [3:0] ADDR_RESERVED  = 4'd15;

    // coefficient loader FSM
    typedef enum logic [1:0] {
        LD_IDLE,
        LD_LOAD,
        LD_CLEAR
    } loader_state_t;

    // filter datapath FSM
    typedef enum logic [1:0] {
        DP_IDLE,
        DP_SHIFT,
        DP_MAC,
        DP_DONE
    } datapath_state_t;

endpackage
